// ==== Makefile ====
# Verilator build and run of the GAT weight load testbench

VERILATOR ?= verilator
TOP       ?= tb_gat_wload
FILELIST  ?= gat_wload.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Finished with errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for failure"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(BIN): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) gat_wload_defines.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$rc -ne 0 ]; then \
	  echo "Simulation failed"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== col_bank.sv ====
// One W column, written once per load; read data lags rd_row by one cycle
`timescale 1ns/1ps
`default_nettype none

`include "gat_wload_defines.svh"

module col_bank (
  input  logic                   clk,
  input  logic                   we,
  input  gat_data_pkg::row_idx_t wr_row,
  input  gat_data_pkg::wgt_t     wr_data,
  input  gat_data_pkg::row_idx_t rd_row,
  output gat_data_pkg::wgt_t     rd_data
);
  import gat_data_pkg::*;

  wgt_t mem [`GAT_F_IN];

  // Simple dual port, registered read
  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_row] <= wr_data;
    end
    rd_data <= mem[rd_row];
  end

endmodule

`default_nettype wire

// ==== gat_ctrl_pkg.sv ====
// FSM encodings of the fetch unit and the projector; literals are prefixed per machine
`default_nettype none

package gat_ctrl_pkg;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_DONE
  } fetch_state_e;

  typedef enum logic [1:0] {
    PROJ_IDLE,
    PROJ_ACCUM,
    PROJ_DRAIN,
    PROJ_HOLD
  } proj_state_e;

endpackage

`default_nettype wire

// ==== gat_data_pkg.sv ====
// Data types of the GAT slice; widths follow gat_wload_defines.svh
`default_nettype none

`include "gat_wload_defines.svh"

package gat_data_pkg;

  // Signed weight or attention element
  typedef logic signed [`GAT_DATA_W-1:0] wgt_t;
  // Signed feature element
  typedef logic signed [`GAT_DATA_W-1:0] feat_t;

  typedef logic [`GAT_WB_ADR_W-1:0] wb_adr_t;

  // Indices into W and a
  typedef logic [$clog2(`GAT_F_IN)-1:0] row_idx_t;
  typedef logic [$clog2(`GAT_F_OUT)-1:0] col_idx_t;
  typedef logic [$clog2(`GAT_A_LEN)-1:0] a_idx_t;

  // 16 products of 8-bit operands fit in 20 bits
  typedef logic signed [19:0] wh_t;
  typedef logic signed [31:0] score_t;

endpackage

`default_nettype wire

// ==== gat_wload.f ====
+incdir+.
gat_data_pkg.sv
gat_ctrl_pkg.sv
wgt_fetch.sv
col_bank.sv
w_loader.sv
wh_projector.sv
gat_wload_top.sv
tb_gat_wload.sv

// ==== gat_wload_defines.svh ====
// Fixed GAT slice sizes; F_OUT and F_IN must stay powers of two for the index typedefs
`ifndef GAT_WLOAD_DEFINES_SVH
`define GAT_WLOAD_DEFINES_SVH

// ==============================
// Data and bus widths
// ==============================

// Weight, attention and feature element width
`define GAT_DATA_W 8

// Word address width of the read-only Wishbone port
`define GAT_WB_ADR_W 8

// ==============================
// Layer shape
// ==============================

// Rows of W, one per input feature
`define GAT_F_IN 16

// Columns of W, one per output feature
`define GAT_F_OUT 4

// Attention vector holds a self half and a neighbour half
`define GAT_A_LEN (2 * `GAT_F_OUT)

// Weight image is W row-major followed by a
`define GAT_W_WORDS (`GAT_F_IN * `GAT_F_OUT)
`define GAT_IMG_WORDS (`GAT_W_WORDS + `GAT_A_LEN)

`endif

// ==== gat_wload_top.sv ====
// GAT weight load and projection slice; features must wait for loaded after each start
`timescale 1ns/1ps
`default_nettype none

`include "gat_wload_defines.svh"

module gat_wload_top (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                start,
  output logic                                wb_cyc,
  output logic                                wb_stb,
  output gat_data_pkg::wb_adr_t               wb_adr,
  input  gat_data_pkg::wgt_t                  wb_dat_i,
  input  logic                                wb_ack,
  output logic                                loaded,
  input  logic                                feat_vld,
  input  gat_data_pkg::feat_t                 feat_data,
  output logic                                feat_rdy,
  output logic                                res_vld,
  output gat_data_pkg::wh_t [`GAT_F_OUT-1:0]  res_wh,
  output gat_data_pkg::score_t                res_self,
  output gat_data_pkg::score_t                res_neigh,
  input  logic                                res_rdy
);
  import gat_data_pkg::*;

  logic                      wgt_vld;
  wgt_t                      wgt_data;
  row_idx_t                  rd_row;
  wgt_t [`GAT_F_OUT-1:0]     rd_w;
  wgt_t [`GAT_A_LEN-1:0]     a_vec;

  // ==============================
  // Producer, buffer, consumer
  // ==============================
  wgt_fetch u_fetch (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_adr   (wb_adr),
    .wb_dat_i (wb_dat_i),
    .wb_ack   (wb_ack),
    .wgt_vld  (wgt_vld),
    .wgt_data (wgt_data)
  );

  w_loader u_loader (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .wgt_vld  (wgt_vld),
    .wgt_data (wgt_data),
    .rd_row   (rd_row),
    .rd_w     (rd_w),
    .a_vec    (a_vec),
    .loaded   (loaded)
  );

  wh_projector u_proj (
    .clk       (clk),
    .rst_n     (rst_n),
    .loaded    (loaded),
    .a_vec     (a_vec),
    .rd_row    (rd_row),
    .rd_w      (rd_w),
    .feat_vld  (feat_vld),
    .feat_data (feat_data),
    .feat_rdy  (feat_rdy),
    .res_vld   (res_vld),
    .res_wh    (res_wh),
    .res_self  (res_self),
    .res_neigh (res_neigh),
    .res_rdy   (res_rdy)
  );

endmodule

`default_nettype wire

// ==== tb_gat_wload.sv ====
// Random image and feature traffic at seed 14; checks WH and scores against an in-bench model
`timescale 1ns/1ps
`default_nettype none

`include "gat_wload_defines.svh"

module tb_gat_wload;
  import gat_data_pkg::*;
  import gat_ctrl_pkg::*;

  localparam int NUM_IMAGES = 2;
  localparam int NODES = 20;
  // Twice the worst-case cycle count at 10 ns per cycle
  localparam longint WATCHDOG_NS = 2 * (NUM_IMAGES * `GAT_IMG_WORDS * 5
                                   + NUM_IMAGES * NODES * (`GAT_F_IN + 8) * 4) * 10;

  logic                        clk = 1'b0;
  logic                        rst_n;
  logic                        start;
  logic                        wb_cyc;
  logic                        wb_stb;
  wb_adr_t                     wb_adr;
  wgt_t                        wb_dat_i;
  logic                        wb_ack;
  logic                        loaded;
  logic                        feat_vld;
  feat_t                       feat_data;
  logic                        feat_rdy;
  logic                        res_vld;
  wh_t [`GAT_F_OUT-1:0]        res_wh;
  score_t                      res_self;
  score_t                      res_neigh;
  logic                        res_rdy;

  wgt_t   img [`GAT_IMG_WORDS];
  feat_t  feats [NODES][`GAT_F_IN];
  wh_t    exp_wh [NODES][`GAT_F_OUT];
  score_t exp_self [NODES];
  score_t exp_neigh [NODES];
  int     ack_cnt;
  int     ack_wait;

  gat_wload_top DUT (.*);

  always #5 clk = ~clk;

  initial begin
    #(WATCHDOG_NS);
    abort_run("Timeout: the run took longer than the worst-case cycle count");
  end

  // ==============================
  // Failure reporting and checks
  // ==============================
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("FAIL %0t: %s is %b, expected %b", $time, name, got, exp);
      abort_run("Status signal check failed");
    end
  endtask

  task automatic check_adr(input wb_adr_t got, input wb_adr_t exp);
    if (got !== exp) begin
      $display("FAIL %0t: wb_adr is %0d, expected %0d", $time, got, exp);
      abort_run("Wishbone address check failed");
    end
  endtask

  task automatic check_wh(input wh_t got, input wh_t exp, input int col);
    if (got !== exp) begin
      $display("FAIL %0t: res_wh[%0d] is %0d, expected %0d", $time, col, got, exp);
      abort_run("WH check failed");
    end
  endtask

  task automatic check_score(input score_t got, input score_t exp, input string name);
    if (got !== exp) begin
      $display("FAIL %0t: %s score is %0d, expected %0d", $time, name, got, exp);
      abort_run("Attention score check failed");
    end
  endtask

  // ==============================
  // Wishbone slave memory
  // ==============================
  // Acks after 0 to 3 wait cycles with the data alongside
  always @(negedge clk) begin
    if (!rst_n) begin
      wb_ack = 1'b0;
      ack_wait = $urandom % 4;
    end else begin
      wb_ack = 1'b0;
      if (wb_cyc && wb_stb) begin
        if (ack_wait == 0) begin
          check_adr(wb_adr, wb_adr_t'(ack_cnt));
          wb_dat_i = img[int'(wb_adr)];
          wb_ack = 1'b1;
          ack_cnt++;
          ack_wait = $urandom % 4;
        end else begin
          ack_wait--;
        end
      end
    end
  end

  // ==============================
  // Reference model
  // ==============================
  task automatic compute_expected();
    int wh_sum [`GAT_F_OUT];
    int self_sum;
    int neigh_sum;
    for (int n = 0; n < NODES; n++) begin
      self_sum = 0;
      neigh_sum = 0;
      for (int j = 0; j < `GAT_F_OUT; j++) begin
        wh_sum[j] = 0;
        for (int r = 0; r < `GAT_F_IN; r++) begin
          wh_sum[j] += int'(feats[n][r]) * int'(img[r * `GAT_F_OUT + j]);
        end
        exp_wh[n][j] = wh_t'(wh_sum[j]);
        self_sum += int'(img[`GAT_W_WORDS + j]) * wh_sum[j];
        neigh_sum += int'(img[`GAT_W_WORDS + `GAT_F_OUT + j]) * wh_sum[j];
      end
      exp_self[n] = score_t'(self_sum);
      exp_neigh[n] = score_t'(neigh_sum);
    end
  endtask

  task automatic load_image();
    for (int i = 0; i < `GAT_IMG_WORDS; i++) begin
      img[i] = wgt_t'($urandom);
    end
    ack_cnt = 0;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_bit(loaded, 1'b0, "loaded after start");
    check_bit(wb_cyc, 1'b1, "wb_cyc after start");
    check_bit(wb_stb, 1'b1, "wb_stb after start");
    while (!loaded) @(negedge clk);
    if (ack_cnt != `GAT_IMG_WORDS) begin
      $display("FAIL %0t: %0d acks, expected %0d", $time, ack_cnt, `GAT_IMG_WORDS);
      abort_run("Wrong number of Wishbone transfers");
    end
    check_bit(wb_cyc, 1'b0, "wb_cyc after load");
    check_bit(wb_stb, 1'b0, "wb_stb after load");
    if (DUT.u_fetch.state_q != FETCH_DONE) begin
      abort_run("Fetch FSM did not reach DONE after the load");
    end
  endtask

  // ==============================
  // Feature and result streams
  // ==============================
  task automatic drive_features();
    int gap;
    for (int n = 0; n < NODES; n++) begin
      for (int r = 0; r < `GAT_F_IN; r++) begin
        gap = $urandom % 3;
        if (gap != 0) begin
          feat_vld = 1'b0;
          repeat (gap) @(negedge clk);
        end
        feat_vld = 1'b1;
        feat_data = feats[n][r];
        while (!feat_rdy) @(negedge clk);
        @(negedge clk);
      end
    end
    feat_vld = 1'b0;
  endtask

  task automatic collect_results();
    int   got_n;
    int   hold;
    logic pending;
    logic just_done;
    got_n = 0;
    hold = 0;
    pending = 1'b0;
    just_done = 1'b0;
    while (got_n < NODES) begin
      // A pending result holds and a taken one does not reappear
      if (pending || just_done) begin
        check_bit(res_vld, pending, "res_vld");
      end
      just_done = 1'b0;
      if (res_vld) begin
        pending = 1'b1;
        for (int j = 0; j < `GAT_F_OUT; j++) begin
          check_wh(res_wh[j], exp_wh[got_n][j], j);
        end
        check_score(res_self, exp_self[got_n], "self");
        check_score(res_neigh, exp_neigh[got_n], "neighbour");
        check_bit(feat_rdy, 1'b0, "feat_rdy with a result pending");
      end
      if (hold == 0) begin
        res_rdy = 1'($urandom % 2);
        hold = $urandom % 5;
      end else begin
        hold--;
      end
      if (res_vld && res_rdy) begin
        got_n++;
        pending = 1'b0;
        just_done = 1'b1;
      end
      @(negedge clk);
    end
    res_rdy = 1'b0;
    check_bit(res_vld, 1'b0, "res_vld after the last result");
  endtask

  task automatic run_nodes();
    for (int n = 0; n < NODES; n++) begin
      for (int r = 0; r < `GAT_F_IN; r++) begin
        feats[n][r] = feat_t'($urandom);
      end
    end
    compute_expected();
    fork
      drive_features();
      collect_results();
    join
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    void'($urandom(14));
    rst_n = 1'b0;
    start = 1'b0;
    wb_ack = 1'b0;
    wb_dat_i = '0;
    feat_vld = 1'b0;
    feat_data = '0;
    res_rdy = 1'b0;
    ack_cnt = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_bit(wb_cyc, 1'b0, "wb_cyc after reset");
    check_bit(wb_stb, 1'b0, "wb_stb after reset");
    check_bit(loaded, 1'b0, "loaded after reset");
    check_bit(feat_rdy, 1'b0, "feat_rdy after reset");
    check_bit(res_vld, 1'b0, "res_vld after reset");
    // Second image reloads over the first
    for (int i = 0; i < NUM_IMAGES; i++) begin
      load_image();
      run_nodes();
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== w_loader.sv ====
// Expects the image in order W row-major then a; a start mid-load is not supported
`timescale 1ns/1ps
`default_nettype none

`include "gat_wload_defines.svh"

module w_loader (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      start,
  input  logic                                      wgt_vld,
  input  gat_data_pkg::wgt_t                        wgt_data,
  input  gat_data_pkg::row_idx_t                    rd_row,
  output gat_data_pkg::wgt_t [`GAT_F_OUT-1:0]       rd_w,
  output gat_data_pkg::wgt_t [`GAT_A_LEN-1:0]       a_vec,
  output logic                                      loaded
);
  import gat_data_pkg::*;

  logic [$clog2(`GAT_IMG_WORDS + 1)-1:0] word_cnt;
  logic                                  in_matrix;
  logic                                  in_image;
  row_idx_t                              wr_row;
  col_idx_t                              wr_col;
  a_idx_t                                a_idx;
  logic [`GAT_F_OUT-1:0]                 bank_we;

  // ==============================
  // Word position in the image
  // ==============================
  assign in_image  = (word_cnt < `GAT_IMG_WORDS);
  assign in_matrix = (word_cnt < `GAT_W_WORDS);
  assign wr_col    = col_idx_t'(word_cnt % `GAT_F_OUT);
  assign wr_row    = row_idx_t'(word_cnt / `GAT_F_OUT);
  assign a_idx     = a_idx_t'(word_cnt - `GAT_W_WORDS);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt <= '0;
      loaded   <= 1'b0;
    end else if (start) begin
      word_cnt <= '0;
      loaded   <= 1'b0;
    end else begin
      if (wgt_vld && in_image) begin
        word_cnt <= word_cnt + 1'b1;
      end
      if (!in_image) begin
        loaded <= 1'b1;
      end
    end
  end

  // ==============================
  // Column banks
  // ==============================
  for (genvar i = 0; i < `GAT_F_OUT; i++) begin : g_bank
    // Only the bank of the current column takes the word
    assign bank_we[i] = wgt_vld && in_matrix && (wr_col == col_idx_t'(i));

    col_bank u_col_bank (
      .clk     (clk),
      .we      (bank_we[i]),
      .wr_row  (wr_row),
      .wr_data (wgt_data),
      .rd_row  (rd_row),
      .rd_data (rd_w[i])
    );
  end

  // Attention vector, filled in order after the matrix
  always_ff @(posedge clk) begin
    if (wgt_vld && !in_matrix && in_image) begin
      a_vec[a_idx] <= wgt_data;
    end
  end

  a_no_word_when_loaded: assert property (@(posedge clk) disable iff (!rst_n)
    loaded |-> !wgt_vld);

endmodule

`default_nettype wire

// ==== wgt_fetch.sv ====
// Wishbone classic read master, one burst-free pass over the image per start
`timescale 1ns/1ps
`default_nettype none

`include "gat_wload_defines.svh"

module wgt_fetch (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output gat_data_pkg::wb_adr_t wb_adr,
  input  gat_data_pkg::wgt_t    wb_dat_i,
  input  logic                  wb_ack,
  output logic                  wgt_vld,
  output gat_data_pkg::wgt_t    wgt_data
);
  import gat_data_pkg::*;
  import gat_ctrl_pkg::*;

  fetch_state_e state_q;
  logic         last_adr;

  assign last_adr = (wb_adr == wb_adr_t'(`GAT_IMG_WORDS - 1));

  // ==============================
  // Bus FSM
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= FETCH_IDLE;
      wb_cyc  <= 1'b0;
      wb_stb  <= 1'b0;
      wb_adr  <= '0;
      wgt_vld <= 1'b0;
    end else begin
      wgt_vld <= 1'b0;
      case (state_q)
        FETCH_IDLE, FETCH_DONE: begin
          if (start) begin
            state_q <= FETCH_REQ;
            wb_cyc  <= 1'b1;
            wb_stb  <= 1'b1;
            wb_adr  <= '0;
          end
        end
        FETCH_REQ: begin
          if (wb_ack) begin
            wgt_vld <= 1'b1;
            if (last_adr) begin
              // Cycle ends after the final word
              state_q <= FETCH_DONE;
              wb_cyc  <= 1'b0;
              wb_stb  <= 1'b0;
            end else begin
              wb_adr <= wb_adr + 1'b1;
            end
          end
        end
        default: state_q <= FETCH_IDLE;
      endcase
    end
  end

  // Word captured on the ack edge
  always_ff @(posedge clk) begin
    if (wb_stb && wb_ack) begin
      wgt_data <= wb_dat_i;
    end
  end

  a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc);

  a_adr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_stb && !wb_ack) |=> $stable(wb_adr));

endmodule

`default_nettype wire

// ==== wh_projector.sv ====
// One node at a time, GAT_F_IN elements per node in row order; needs loaded before the first
`timescale 1ns/1ps
`default_nettype none

`include "gat_wload_defines.svh"

module wh_projector (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 loaded,
  input  gat_data_pkg::wgt_t [`GAT_A_LEN-1:0]  a_vec,
  output gat_data_pkg::row_idx_t               rd_row,
  input  gat_data_pkg::wgt_t [`GAT_F_OUT-1:0]  rd_w,
  input  logic                                 feat_vld,
  input  gat_data_pkg::feat_t                  feat_data,
  output logic                                 feat_rdy,
  output logic                                 res_vld,
  output gat_data_pkg::wh_t [`GAT_F_OUT-1:0]   res_wh,
  output gat_data_pkg::score_t                 res_self,
  output gat_data_pkg::score_t                 res_neigh,
  input  logic                                 res_rdy
);
  import gat_data_pkg::*;
  import gat_ctrl_pkg::*;

  proj_state_e           state_q;
  row_idx_t              elem_cnt;
  logic                  feat_fire;
  logic                  last_elem;
  logic                  acc_en;
  logic                  score_en;
  feat_t                 feat_q;
  wh_t [`GAT_F_OUT-1:0]  acc;
  score_t                self_sum;
  score_t                neigh_sum;

  assign feat_rdy  = loaded && ((state_q == PROJ_IDLE) || (state_q == PROJ_ACCUM));
  assign feat_fire = feat_vld && feat_rdy;
  assign last_elem = (elem_cnt == row_idx_t'(`GAT_F_IN - 1));
  // Element index doubles as the bank row
  assign rd_row    = elem_cnt;
  assign res_wh    = acc;
  // Last accumulate has landed once the delayed valid is gone
  assign score_en  = (state_q == PROJ_DRAIN) && !acc_en;

  // ==============================
  // Attention partial scores
  // ==============================
  always_comb begin
    self_sum  = '0;
    neigh_sum = '0;
    for (int j = 0; j < `GAT_F_OUT; j++) begin
      self_sum  = self_sum + score_t'(a_vec[j]) * score_t'(acc[j]);
      neigh_sum = neigh_sum + score_t'(a_vec[`GAT_F_OUT + j]) * score_t'(acc[j]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= PROJ_IDLE;
      elem_cnt <= '0;
      acc_en   <= 1'b0;
      res_vld  <= 1'b0;
      acc      <= '0;
    end else begin
      acc_en <= feat_fire;
      if (feat_fire) begin
        elem_cnt <= elem_cnt + 1'b1;
      end
      // Feature was delayed a cycle to meet the bank data
      if (acc_en) begin
        for (int j = 0; j < `GAT_F_OUT; j++) begin
          acc[j] <= acc[j] + wh_t'(feat_q) * wh_t'(rd_w[j]);
        end
      end
      case (state_q)
        PROJ_IDLE: begin
          if (feat_fire) begin
            state_q <= last_elem ? PROJ_DRAIN : PROJ_ACCUM;
          end
        end
        PROJ_ACCUM: begin
          if (feat_fire && last_elem) begin
            state_q <= PROJ_DRAIN;
          end
        end
        PROJ_DRAIN: begin
          if (score_en) begin
            res_vld <= 1'b1;
            state_q <= PROJ_HOLD;
          end
        end
        PROJ_HOLD: begin
          if (res_rdy) begin
            res_vld <= 1'b0;
            acc     <= '0;
            state_q <= PROJ_IDLE;
          end
        end
        default: state_q <= PROJ_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (feat_fire) begin
      feat_q <= feat_data;
    end
    if (score_en) begin
      res_self  <= self_sum;
      res_neigh <= neigh_sum;
    end
  end

  a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (res_vld && !res_rdy) |=> (res_vld && $stable(res_wh) && $stable(res_self)
                                && $stable(res_neigh)));

endmodule

`default_nettype wire
